// File: dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Byte address width
`define DMA_ADDR_W 16

`define DMA_DATA_W 32

// Bursts carry 1 to 16 words
`define DMA_BLEN_W 5

// FIFO depth matches the largest burst
`define DMA_FIFO_AW 4

// Transfer length in words
`define DMA_XFER_W 12

`endif

// File: dma_pkg.sv
`default_nettype none

`include "dma_macros.svh"

package dma_pkg;

   // Transfer command
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_XFER_W-1:0] count;
   } dma_cmd_t;

   // Burst read request, length in words
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_BLEN_W-1:0] len;
   } mem_req_t;

   // One response beat
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: dma_burst_planner.sv
`default_nettype none

`include "dma_macros.svh"

module dma_burst_planner
   import dma_pkg::*;
(
   input  wire                      clk_i,
   input  wire                      rst_n_i,
   input  wire dma_cmd_t            cmd_i,
   input  wire                      cmd_valid_i,
   output logic                     cmd_ready_o,
   input  wire  [`DMA_BLEN_W-1:0]   max_len_i,
   input  wire  [`DMA_FIFO_AW:0]    fifo_level_i,
   input  wire                      engine_busy_i,
   output mem_req_t                 burst_req_o,
   output logic                     burst_start_o,
   output logic                     busy_o
);

   localparam logic [`DMA_FIFO_AW:0] FIFO_DEPTH = 1 << `DMA_FIFO_AW;

   typedef enum logic {
      WAIT_START,
      WAIT_SPACE
   } state_t;

   state_t                  state_q;
   state_t                  state_d;
   logic [`DMA_XFER_W-1:0]  remain_q;
   logic [`DMA_XFER_W-1:0]  remain_d;
   logic [`DMA_ADDR_W-1:0]  addr_q;
   logic [`DMA_ADDR_W-1:0]  addr_d;
   logic [`DMA_FIFO_AW:0]   space;
   logic [`DMA_XFER_W-1:0]  space_ext;
   logic [`DMA_XFER_W-1:0]  max_ext;
   logic [`DMA_XFER_W-1:0]  len_ext;
   logic [`DMA_BLEN_W-1:0]  burst_len;

   // Free FIFO space once all earlier bursts have landed
   assign space     = FIFO_DEPTH - fifo_level_i;
   assign space_ext = {{(`DMA_XFER_W-`DMA_FIFO_AW-1){1'b0}}, space};
   assign max_ext   = {{(`DMA_XFER_W-`DMA_BLEN_W){1'b0}}, max_len_i};

   // Tail of the transfer or a full burst
   assign len_ext   = (remain_q < max_ext) ? remain_q : max_ext;
   assign burst_len = len_ext[`DMA_BLEN_W-1:0];

   assign burst_start_o = (state_q == WAIT_SPACE) && !engine_busy_i
                          && (remain_q != '0) && (space_ext >= len_ext);

   assign burst_req_o.addr = addr_q;
   assign burst_req_o.len  = burst_len;

   assign cmd_ready_o = (state_q == WAIT_START);
   assign busy_o      = (state_q == WAIT_SPACE);

   always_comb begin
      state_d  = state_q;
      remain_d = remain_q;
      addr_d   = addr_q;
      case (state_q)
         WAIT_START: begin
            if (cmd_valid_i) begin
               remain_d = cmd_i.count;
               addr_d   = cmd_i.addr;
               state_d  = WAIT_SPACE;
            end
         end
         default: begin
            if (burst_start_o) begin
               remain_d = remain_q - len_ext;
               addr_d   = addr_q + {{(`DMA_ADDR_W-`DMA_BLEN_W-2){1'b0}}, burst_len, 2'b00};
            end else if (!engine_busy_i && (remain_q == '0)) begin
               state_d = WAIT_START;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= WAIT_START;
         remain_q <= '0;
      end else begin
         state_q  <= state_d;
         remain_q <= remain_d;
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q <= addr_d;
   end

   a_len_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      burst_start_o |-> (burst_len != '0) && (burst_len <= max_len_i));

   // Words of the burst must fit in the FIFO as it stands
   a_len_space: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      burst_start_o |-> (int'(fifo_level_i) + int'(burst_len) <= int'(FIFO_DEPTH)));

endmodule

`default_nettype wire

// File: dma_stream_fifo.sv
`default_nettype none

`include "dma_macros.svh"

module dma_stream_fifo #(
   parameter int DATA_W = `DMA_DATA_W,
   parameter int ADDR_W = `DMA_FIFO_AW
) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 wr_en_i,
   input  wire  [DATA_W-1:0]   wr_data_i,
   output logic                full_o,
   output logic [ADDR_W:0]     level_o,
   output logic [DATA_W-1:0]   out_data_o,
   output logic                out_valid_o,
   input  wire                 out_ready_i
);

   localparam logic [ADDR_W:0] DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W:0]   level_q;
   logic              rd_en;

   assign out_valid_o = (level_q != '0);
   assign out_data_o  = mem[rd_ptr_q];
   assign full_o      = (level_q == DEPTH);
   assign level_o     = level_q;
   assign rd_en       = out_valid_o && out_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Pointers wrap on their own, level tracks the difference
         case ({wr_en_i, rd_en})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_en_i |-> !full_o);

endmodule

`default_nettype wire

// File: dma_read_channel.sv
`default_nettype none

`include "dma_macros.svh"

module dma_read_channel
   import dma_pkg::*;
(
   input  wire                      clk_i,
   input  wire                      rst_n_i,
   input  wire dma_cmd_t            cmd_i,
   input  wire                      cmd_valid_i,
   output logic                     cmd_ready_o,
   input  wire  [`DMA_BLEN_W-1:0]   max_len_i,
   output logic                     busy_o,
   output mem_req_t                 req_o,
   output logic                     req_valid_o,
   input  wire                      req_ready_i,
   input  wire mem_rsp_t            rsp_i,
   input  wire                      rsp_valid_i,
   output logic                     rsp_ready_o,
   output logic [`DMA_DATA_W-1:0]   out_data_o,
   output logic                     out_valid_o,
   input  wire                      out_ready_i
);

   logic [`DMA_FIFO_AW:0]  fifo_level;
   mem_req_t               burst_req;
   mem_req_t               req_q;
   logic                   burst_start;
   logic                   eng_busy_q;
   logic                   req_pend_q;
   logic [`DMA_BLEN_W-1:0] beats_left_q;
   logic                   beat_wr;

   dma_burst_planner planner_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cmd_i         (cmd_i),
      .cmd_valid_i   (cmd_valid_i),
      .cmd_ready_o   (cmd_ready_o),
      .max_len_i     (max_len_i),
      .fifo_level_i  (fifo_level),
      .engine_busy_i (eng_busy_q),
      .burst_req_o   (burst_req),
      .burst_start_o (burst_start),
      .busy_o        (busy_o)
   );

   // New burst goes straight to the bus, later cycles replay the latched copy
   assign req_valid_o = burst_start || req_pend_q;
   assign req_o       = req_pend_q ? req_q : burst_req;

   // Space was reserved before the burst started
   assign rsp_ready_o = 1'b1;
   assign beat_wr     = rsp_valid_i && rsp_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         eng_busy_q   <= 1'b0;
         req_pend_q   <= 1'b0;
         beats_left_q <= '0;
      end else if (burst_start) begin
         eng_busy_q   <= 1'b1;
         req_pend_q   <= !req_ready_i;
         beats_left_q <= burst_req.len;
      end else begin
         if (req_pend_q && req_ready_i) begin
            req_pend_q <= 1'b0;
         end
         if (beat_wr) begin
            beats_left_q <= beats_left_q - 1'b1;
            if (rsp_i.last) begin
               eng_busy_q <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (burst_start) begin
         req_q <= burst_req;
      end
   end

   dma_stream_fifo #(
      .DATA_W (`DMA_DATA_W),
      .ADDR_W (`DMA_FIFO_AW)
   ) fifo_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_en_i     (beat_wr),
      .wr_data_i   (rsp_i.data),
      .full_o      (),
      .level_o     (fifo_level),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   // Memory and arbiter must end the burst on the counted beat
   a_last_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      beat_wr |-> (rsp_i.last == (beats_left_q == `DMA_BLEN_W'(1))));

endmodule

`default_nettype wire

// File: mem_bus_arbiter.sv
`default_nettype none

`include "dma_macros.svh"

module mem_bus_arbiter
   import dma_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_n_i,
   input  wire mem_req_t   req_i [2],
   input  wire             req_valid_i [2],
   output logic            req_ready_o [2],
   output mem_rsp_t        rsp_o [2],
   output logic            rsp_valid_o [2],
   input  wire             rsp_ready_i [2],
   output mem_req_t        mem_req_o,
   output logic            mem_req_valid_o,
   input  wire             mem_req_ready_i,
   input  wire mem_rsp_t   mem_rsp_i,
   input  wire             mem_rsp_valid_i,
   output logic            mem_rsp_ready_o
);

   logic owner_valid_q;
   logic owner_q;
   logic last_q;
   logic hold_q;
   logic hold_sel_q;
   logic sel;
   logic req_fire;

   // A stalled request keeps its channel until the bus takes it
   always_comb begin
      if (hold_q) begin
         sel = hold_sel_q;
      end else if (req_valid_i[0] && req_valid_i[1]) begin
         sel = ~last_q;
      end else begin
         sel = req_valid_i[1];
      end
   end

   assign mem_req_o       = req_i[sel];
   assign mem_req_valid_o = !owner_valid_q && req_valid_i[sel];
   assign req_fire        = mem_req_valid_o && mem_req_ready_i;
   assign mem_rsp_ready_o = owner_valid_q && rsp_ready_i[owner_q];

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         req_ready_o[i] = !owner_valid_q && (sel == i[0]) && mem_req_ready_i;
         rsp_o[i]       = mem_rsp_i;
         rsp_valid_o[i] = mem_rsp_valid_i && owner_valid_q && (owner_q == i[0]);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner_valid_q <= 1'b0;
         owner_q       <= 1'b0;
         last_q        <= 1'b1;
         hold_q        <= 1'b0;
         hold_sel_q    <= 1'b0;
      end else begin
         if (req_fire) begin
            owner_valid_q <= 1'b1;
            owner_q       <= sel;
            last_q        <= sel;
            hold_q        <= 1'b0;
         end else if (mem_req_valid_o) begin
            hold_q     <= 1'b1;
            hold_sel_q <= sel;
         end
         // Grant is released by the last beat of the burst
         if (mem_rsp_valid_i && mem_rsp_ready_o && mem_rsp_i.last) begin
            owner_valid_q <= 1'b0;
         end
      end
   end

   // The memory only returns beats for an accepted request
   a_rsp_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_rsp_valid_i |-> owner_valid_q);

endmodule

`default_nettype wire

// File: dma_read_top.sv
`default_nettype none

`include "dma_macros.svh"

module dma_read_top
   import dma_pkg::*;
(
   input  wire                      clk_i,
   input  wire                      rst_n_i,
   input  wire dma_cmd_t            ch0_cmd_i,
   input  wire                      ch0_cmd_valid_i,
   output logic                     ch0_cmd_ready_o,
   output logic                     ch0_busy_o,
   output logic [`DMA_DATA_W-1:0]   ch0_out_o,
   output logic                     ch0_out_valid_o,
   input  wire                      ch0_out_ready_i,
   input  wire dma_cmd_t            ch1_cmd_i,
   input  wire                      ch1_cmd_valid_i,
   output logic                     ch1_cmd_ready_o,
   output logic                     ch1_busy_o,
   output logic [`DMA_DATA_W-1:0]   ch1_out_o,
   output logic                     ch1_out_valid_o,
   input  wire                      ch1_out_ready_i,
   input  wire  [`DMA_BLEN_W-1:0]   max_len_i,
   output mem_req_t                 mem_req_o,
   output logic                     mem_req_valid_o,
   input  wire                      mem_req_ready_i,
   input  wire mem_rsp_t            mem_rsp_i,
   input  wire                      mem_rsp_valid_i,
   output logic                     mem_rsp_ready_o
);

   mem_req_t ch_req [2];
   logic     ch_req_valid [2];
   logic     ch_req_ready [2];
   mem_rsp_t ch_rsp [2];
   logic     ch_rsp_valid [2];
   logic     ch_rsp_ready [2];

   dma_read_channel ch0_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_i       (ch0_cmd_i),
      .cmd_valid_i (ch0_cmd_valid_i),
      .cmd_ready_o (ch0_cmd_ready_o),
      .max_len_i   (max_len_i),
      .busy_o      (ch0_busy_o),
      .req_o       (ch_req[0]),
      .req_valid_o (ch_req_valid[0]),
      .req_ready_i (ch_req_ready[0]),
      .rsp_i       (ch_rsp[0]),
      .rsp_valid_i (ch_rsp_valid[0]),
      .rsp_ready_o (ch_rsp_ready[0]),
      .out_data_o  (ch0_out_o),
      .out_valid_o (ch0_out_valid_o),
      .out_ready_i (ch0_out_ready_i)
   );

   dma_read_channel ch1_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_i       (ch1_cmd_i),
      .cmd_valid_i (ch1_cmd_valid_i),
      .cmd_ready_o (ch1_cmd_ready_o),
      .max_len_i   (max_len_i),
      .busy_o      (ch1_busy_o),
      .req_o       (ch_req[1]),
      .req_valid_o (ch_req_valid[1]),
      .req_ready_i (ch_req_ready[1]),
      .rsp_i       (ch_rsp[1]),
      .rsp_valid_i (ch_rsp_valid[1]),
      .rsp_ready_o (ch_rsp_ready[1]),
      .out_data_o  (ch1_out_o),
      .out_valid_o (ch1_out_valid_o),
      .out_ready_i (ch1_out_ready_i)
   );

   mem_bus_arbiter arb_inst (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (ch_req),
      .req_valid_i     (ch_req_valid),
      .req_ready_o     (ch_req_ready),
      .rsp_o           (ch_rsp),
      .rsp_valid_o     (ch_rsp_valid),
      .rsp_ready_i     (ch_rsp_ready),
      .mem_req_o       (mem_req_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .mem_rsp_i       (mem_rsp_i),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_ready_o (mem_rsp_ready_o)
   );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

`include "dma_macros.svh"

module tb_mem_model
   import dma_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h0f2e_519a
) (
   input  wire             clk_i,
   input  wire             rst_n_i,
   input  wire mem_req_t   req_i,
   input  wire             req_valid_i,
   output logic            req_ready_o,
   output mem_rsp_t        rsp_o,
   output logic            rsp_valid_o,
   input  wire             rsp_ready_i
);

   integer                 seed;
   logic                   busy;
   logic [`DMA_ADDR_W-1:0] addr;
   logic [`DMA_BLEN_W-1:0] left;
   logic [31:0]            roll;

   initial begin
      seed        = SEED;
      busy        = 1'b0;
      addr        = '0;
      left        = '0;
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
      rsp_o       = '0;
      forever begin
         @(posedge clk_i);
         if (!rst_n_i) begin
            busy = 1'b0;
         end else if (busy && rsp_valid_o && rsp_ready_i) begin
            addr = addr + `DMA_ADDR_W'(4);
            left = left - `DMA_BLEN_W'(1);
            busy = (left != '0);
         end else if (!busy && req_valid_i && req_ready_o) begin
            addr = req_i.addr;
            left = req_i.len;
            busy = 1'b1;
         end
         #2;
         // About one cycle in four stalls on each side
         roll        = $random(seed);
         req_ready_o = !busy && rst_n_i && (roll[1:0] != 2'b00);
         rsp_valid_o = busy && (roll[3:2] != 2'b00);
         rsp_o.data  = `DMA_DATA_W'(addr);
         rsp_o.last  = (left == `DMA_BLEN_W'(1));
      end
   end

endmodule

`default_nettype wire

// File: tb_dma_read.sv
`default_nettype none

`include "dma_macros.svh"

module tb_dma_read
   import dma_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int TOTAL_WORDS  = 7 + 40 + 48 + 2 * 30;
   // Each word may wait on bus stalls and a random output ready
   localparam int LIMIT_CYCLES = TOTAL_WORDS * 12 + 600;
   localparam int FIFO_DEPTH   = 1 << `DMA_FIFO_AW;

   logic                   clk;
   logic                   rst_n;
   dma_cmd_t               cmd [2];
   logic                   cmd_valid [2];
   logic                   cmd_ready [2];
   logic                   busy [2];
   logic [`DMA_DATA_W-1:0] out_data [2];
   logic                   out_valid [2];
   logic                   out_ready [2];
   logic [`DMA_BLEN_W-1:0] max_len;
   mem_req_t               mem_req;
   logic                   mem_req_valid;
   logic                   mem_req_ready;
   mem_rsp_t               mem_rsp;
   logic                   mem_rsp_valid;
   logic                   mem_rsp_ready;

   logic [`DMA_ADDR_W-1:0] bus_addr [2];
   logic [`DMA_XFER_W-1:0] bus_left [2];
   logic [`DMA_ADDR_W-1:0] exp_addr [2];
   logic [`DMA_XFER_W-1:0] exp_left [2];
   int                     fill [2];
   logic                   owner;
   logic                   last_served;
   logic                   req_wait_q;
   logic                   tie_q;
   logic                   tie_now;
   logic                   req_fire;
   logic                   rsp_fire;
   logic                   req_ch;
   logic [1:0]             ready_mode [2];
   integer                 seed = 32'h0f2e_519a;
   int                     mismatches;
   int                     failures;

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   dma_read_top dut0 (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .ch0_cmd_i       (cmd[0]),
      .ch0_cmd_valid_i (cmd_valid[0]),
      .ch0_cmd_ready_o (cmd_ready[0]),
      .ch0_busy_o      (busy[0]),
      .ch0_out_o       (out_data[0]),
      .ch0_out_valid_o (out_valid[0]),
      .ch0_out_ready_i (out_ready[0]),
      .ch1_cmd_i       (cmd[1]),
      .ch1_cmd_valid_i (cmd_valid[1]),
      .ch1_cmd_ready_o (cmd_ready[1]),
      .ch1_busy_o      (busy[1]),
      .ch1_out_o       (out_data[1]),
      .ch1_out_valid_o (out_valid[1]),
      .ch1_out_ready_i (out_ready[1]),
      .max_len_i       (max_len),
      .mem_req_o       (mem_req),
      .mem_req_valid_o (mem_req_valid),
      .mem_req_ready_i (mem_req_ready),
      .mem_rsp_i       (mem_rsp),
      .mem_rsp_valid_i (mem_rsp_valid),
      .mem_rsp_ready_o (mem_rsp_ready)
   );

   tb_mem_model mem0 (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .req_i       (mem_req),
      .req_valid_i (mem_req_valid),
      .req_ready_o (mem_req_ready),
      .rsp_o       (mem_rsp),
      .rsp_valid_o (mem_rsp_valid),
      .rsp_ready_i (mem_rsp_ready)
   );

   assign req_fire = mem_req_valid && mem_req_ready;
   assign rsp_fire = mem_rsp_valid && mem_rsp_ready;
   // Channel 1 works in the upper half of the address space
   assign req_ch   = mem_req.addr[`DMA_ADDR_W-1];
   // Tie as seen when the stalled request was first chosen
   assign tie_now  = req_wait_q ? tie_q : (dut0.ch_req_valid[0] && dut0.ch_req_valid[1]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner       <= 1'b0;
         last_served <= 1'b1;
         req_wait_q  <= 1'b0;
         tie_q       <= 1'b0;
         for (int c = 0; c < 2; c++) begin
            bus_addr[c] <= '0;
            bus_left[c] <= '0;
            exp_addr[c] <= '0;
            exp_left[c] <= '0;
            fill[c]     <= 0;
         end
      end else begin
         req_wait_q <= mem_req_valid && !mem_req_ready;
         tie_q      <= tie_now;
         if (req_fire) begin
            bus_addr[req_ch] <= bus_addr[req_ch] + `DMA_ADDR_W'({mem_req.len, 2'b00});
            bus_left[req_ch] <= bus_left[req_ch] - `DMA_XFER_W'(mem_req.len);
            owner            <= req_ch;
            last_served      <= req_ch;
         end
         for (int c = 0; c < 2; c++) begin
            if (cmd_valid[c] && cmd_ready[c]) begin
               bus_addr[c] <= cmd[c].addr;
               bus_left[c] <= cmd[c].count;
               exp_addr[c] <= cmd[c].addr;
               exp_left[c] <= cmd[c].count;
            end
            if (out_valid[c] && out_ready[c]) begin
               exp_addr[c] <= exp_addr[c] + `DMA_ADDR_W'(4);
               exp_left[c] <= exp_left[c] - `DMA_XFER_W'(1);
            end
            fill[c] <= fill[c] + ((rsp_fire && owner == c[0]) ? 1 : 0)
                       - ((out_valid[c] && out_ready[c]) ? 1 : 0);
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatches = mismatches + 1;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic report_failure(input string what);
      failures = failures + 1;
      $display("error at %0t: %s", $time, what);
   endtask

   // Ready, busy, request valid, output valids
   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      {cmd_ready[0], cmd_ready[1], busy[0], busy[1], mem_req_valid, out_valid[0],
       out_valid[1]} == 7'b110_0000)
      else report_mismatch("reset outputs", 32'($sampled({cmd_ready[0], cmd_ready[1],
         busy[0], busy[1], mem_req_valid, out_valid[0], out_valid[1]})), 32'h60);

   a_req_len: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid |-> (mem_req.len != '0) && (mem_req.len <= max_len))
      else report_failure("bus request length outside 1 to max_len_i");

   a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire |-> mem_req.addr == bus_addr[req_ch])
      else report_mismatch("mem_req_o.addr", 32'($sampled(mem_req.addr)),
         32'($sampled(bus_addr[req_ch])));

   a_req_left: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire |-> `DMA_XFER_W'(mem_req.len) <= bus_left[req_ch])
      else report_failure("bus request runs past the end of its transfer");

   a_req_fits: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire |-> fill[req_ch] + int'(mem_req.len) <= FIFO_DEPTH)
      else report_failure("bus request would overflow the channel FIFO");

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req_wait_q |-> mem_req_valid && (mem_req == $past(mem_req)))
      else report_failure("stalled bus request changed or was dropped");

   // Channels reserve FIFO space, so every beat of a burst is taken at once
   a_rsp_ready: assert property (@(posedge clk) disable iff (!rst_n)
      mem_rsp_valid |-> mem_rsp_ready)
      else report_mismatch("mem_rsp_ready_o", 32'($sampled(mem_rsp_ready)), 32'h1);

   a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire && tie_now |-> req_ch != last_served)
      else report_mismatch("granted channel", 32'($sampled(req_ch)),
         32'($sampled(!last_served)));

   for (genvar c = 0; c < 2; c++) begin : g_stream
      a_data: assert property (@(posedge clk) disable iff (!rst_n)
         out_valid[c] && out_ready[c] |-> out_data[c] == `DMA_DATA_W'(exp_addr[c]))
         else report_mismatch($sformatf("ch%0d_out_o", c), 32'($sampled(out_data[c])),
            32'($sampled(exp_addr[c])));

      a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
         out_valid[c] |-> exp_left[c] != '0)
         else report_failure($sformatf("ch%0d stream shows a word beyond its transfer", c));
   end

   // Mode 0 holds output ready high, 1 holds it low and 2 toggles it randomly
   initial begin
      logic [31:0] roll;
      logic [1:0]  mode_now [2];
      out_ready[0] = 1'b1;
      out_ready[1] = 1'b1;
      forever begin
         @(posedge clk);
         mode_now = ready_mode;
         #2;
         roll = $random(seed);
         for (int c = 0; c < 2; c++) begin
            case (mode_now[c])
               2'd0:    out_ready[c] = 1'b1;
               2'd1:    out_ready[c] = 1'b0;
               default: out_ready[c] = roll[c];
            endcase
         end
      end
   end

   task automatic send_cmd(input int c, input logic [`DMA_ADDR_W-1:0] addr,
                           input logic [`DMA_XFER_W-1:0] count);
      cmd[c].addr  = addr;
      cmd[c].count = count;
      cmd_valid[c] = 1'b1;
      do begin
         @(posedge clk);
      end while (!cmd_ready[c]);
      #2;
      cmd_valid[c] = 1'b0;
   endtask

   task automatic wait_done(input int c);
      do begin
         @(posedge clk);
      end while ((exp_left[c] != '0) || busy[c]);
      #2;
   endtask

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      failures = failures + 1;
      $display("timeout after %0d cycles, a transfer never finished", LIMIT_CYCLES);
      $display("mismatches: %0d, other errors: %0d", mismatches, failures);
      $display("sim failed");
      $finish;
   end

   initial begin
      mismatches = 0;
      failures   = 0;
      rst_n      = 1'b0;
      max_len    = `DMA_BLEN_W'(16);
      for (int c = 0; c < 2; c++) begin
         cmd[c]        = '0;
         cmd_valid[c]  = 1'b0;
         ready_mode[c] = 2'd0;
      end
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Short transfer fits one burst
      send_cmd(0, 16'h0100, 12'd7);
      wait_done(0);

      max_len = `DMA_BLEN_W'(6);
      send_cmd(0, 16'h0400, 12'd40);
      wait_done(0);

      // Stalled stream fills the FIFO first
      max_len       = `DMA_BLEN_W'(16);
      ready_mode[1] = 2'd1;
      send_cmd(1, 16'h8000, 12'd48);
      repeat (60) @(posedge clk);
      #2;
      ready_mode[1] = 2'd2;
      wait_done(1);

      max_len       = `DMA_BLEN_W'(5);
      ready_mode[0] = 2'd2;
      ready_mode[1] = 2'd0;
      fork
         send_cmd(0, 16'h1000, 12'd30);
         send_cmd(1, 16'h9000, 12'd30);
      join
      wait_done(0);
      wait_done(1);

      $display("mismatches: %0d, other errors: %0d", mismatches, failures);
      if ((mismatches == 0) && (failures == 0)) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
dma_pkg.sv
dma_burst_planner.sv
dma_stream_fifo.sv
dma_read_channel.sv
mem_bus_arbiter.sv
dma_read_top.sv
tb_mem_model.sv
tb_dma_read.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_dma_read -f all.f -o tb_sim \
   > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; cat sim.log; exit 1; }
